//--- mul_pkg.sv
package mul_pkg;

    // operand and result width
    localparam int DATA_W = 32;
    // register file address width
    localparam int ADDR_W = 5;
    // commit id width
    localparam int CID_W = 4;

    // shift-add iterations per multiply
    localparam int MUL_CYCLES = 32;
    localparam int CNT_W = $clog2(MUL_CYCLES);

    // number of multiplier cores behind the dispatcher
    localparam int NUM_UNITS = 2;

    // configuration addresses
    localparam logic CFG_ADDR_MASK = 1'b0;
    localparam logic CFG_ADDR_COUNT = 1'b1;

    // rv32m multiply forms
    typedef enum logic [1:0] {
        OP_MUL    = 2'b00,
        OP_MULH   = 2'b01,
        OP_MULHSU = 2'b10,
        OP_MULHU  = 2'b11
    } mul_op_e;

    // issue request, 75 bits
    typedef struct packed {
        mul_op_e             op;
        logic [DATA_W-1:0]   rs1;
        logic [DATA_W-1:0]   rs2;
        logic [ADDR_W-1:0]   waddr;
        logic [CID_W-1:0]    commit_id;
    } mul_req_t;

    // write-back payload, 41 bits
    typedef struct packed {
        logic [DATA_W-1:0]   wdata;
        logic [ADDR_W-1:0]   waddr;
        logic [CID_W-1:0]    commit_id;
    } mul_wb_t;

endpackage

//--- mul_core.sv
module mul_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start_i,
    input  mul_pkg::mul_op_e           op_i,
    input  logic [mul_pkg::DATA_W-1:0] a_i,
    input  logic [mul_pkg::DATA_W-1:0] b_i,
    input  logic                       ready_i,
    output logic [mul_pkg::DATA_W-1:0] result_o,
    output logic                       busy_o,
    output logic                       valid_o
);

    logic                           a_signed;
    logic                           b_signed;
    logic                           a_neg;
    logic                           b_neg;
    logic [mul_pkg::DATA_W-1:0]     a_mag;
    logic [mul_pkg::DATA_W-1:0]     b_mag;

    logic [2*mul_pkg::DATA_W-1:0]   mcand_q;
    logic [mul_pkg::DATA_W-1:0]     mplier_q;
    logic [2*mul_pkg::DATA_W-1:0]   acc_q;
    logic [2*mul_pkg::DATA_W-1:0]   acc_nxt;
    logic [2*mul_pkg::DATA_W-1:0]   prod;
    logic                           neg_q;
    logic                           hi_q;
    logic [mul_pkg::CNT_W-1:0]      cnt_q;
    logic                           last_step;

    // mulhu is the only form with unsigned rs1
    assign a_signed = (op_i != mul_pkg::OP_MULHU);
    // mul low word is the same either way, so treat it as signed
    assign b_signed = (op_i == mul_pkg::OP_MUL) || (op_i == mul_pkg::OP_MULH);

    assign a_neg = a_signed && a_i[mul_pkg::DATA_W-1];
    assign b_neg = b_signed && b_i[mul_pkg::DATA_W-1];

    // most negative value maps onto 2^31 as an unsigned magnitude
    assign a_mag = a_neg ? (~a_i + 1'b1) : a_i;
    assign b_mag = b_neg ? (~b_i + 1'b1) : b_i;

    // one shift-add step
    assign acc_nxt = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

    // sign fixup on the final partial sum
    assign prod = neg_q ? (~acc_nxt + 1'b1) : acc_nxt;

    assign last_step = (int'(cnt_q) == mul_pkg::MUL_CYCLES - 1);

    // control: busy through the iterations, valid until the result is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o  <= 1'b0;
            valid_o <= 1'b0;
            cnt_q   <= '0;
        end else if (start_i) begin
            busy_o <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_o) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_step) begin
                busy_o  <= 1'b0;
                valid_o <= 1'b1;
            end
        end else if (valid_o && ready_i) begin
            valid_o <= 1'b0;
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand_q  <= {{mul_pkg::DATA_W{1'b0}}, a_mag};
            mplier_q <= b_mag;
            acc_q    <= '0;
            neg_q    <= a_neg ^ b_neg;
            hi_q     <= (op_i != mul_pkg::OP_MUL);
        end else if (busy_o) begin
            acc_q    <= acc_nxt;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
            // last step lands straight in the result register
            if (last_step) begin
                result_o <= hi_q ? prod[2*mul_pkg::DATA_W-1:mul_pkg::DATA_W]
                                 : prod[mul_pkg::DATA_W-1:0];
            end
        end
    end

endmodule

//--- mul_regs.sv
module mul_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_we_i,
    input  logic                          cfg_addr_i,
    input  logic [mul_pkg::DATA_W-1:0]    cfg_wdata_i,
    input  logic                          retire_i,
    output logic [mul_pkg::DATA_W-1:0]    cfg_rdata_o,
    output logic [mul_pkg::NUM_UNITS-1:0] unit_en_o
);

    logic [mul_pkg::DATA_W-1:0] retire_cnt_q;
    logic                       wr_mask;
    logic                       wr_count;

    assign wr_mask  = cfg_we_i && (cfg_addr_i == mul_pkg::CFG_ADDR_MASK);
    assign wr_count = cfg_we_i && (cfg_addr_i == mul_pkg::CFG_ADDR_COUNT);

    // enable mask, all units on out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unit_en_o <= '1;
        end else if (wr_mask) begin
            unit_en_o <= cfg_wdata_i[mul_pkg::NUM_UNITS-1:0];
        end
    end

    // retired results; any write to the count address clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_cnt_q <= '0;
        end else if (wr_count) begin
            retire_cnt_q <= '0;
        end else if (retire_i) begin
            retire_cnt_q <= retire_cnt_q + 1'b1;
        end
    end

    // read mux
    always_comb begin
        if (cfg_addr_i == mul_pkg::CFG_ADDR_COUNT) begin
            cfg_rdata_o = retire_cnt_q;
        end else begin
            cfg_rdata_o = '0;
            cfg_rdata_o[mul_pkg::NUM_UNITS-1:0] = unit_en_o;
        end
    end

endmodule

//--- mul_unit.sv
module mul_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_i,
    input  mul_pkg::mul_req_t             req_data_i,
    input  logic                          int_i,
    input  logic [mul_pkg::NUM_UNITS-1:0] unit_en_i,
    input  logic                          wb_ready_i,
    output logic                          stall_o,
    output logic                          wb_valid_o,
    output mul_pkg::mul_wb_t              wb_data_o,
    output logic                          retire_o
);

    logic                                               take;
    logic                                               cand_valid;
    mul_pkg::mul_req_t                                  cand;

    // skid buffer
    logic                                               buf_valid_q;
    mul_pkg::mul_req_t                                  buf_q;

    logic [mul_pkg::NUM_UNITS-1:0]                      core_start;
    logic [mul_pkg::NUM_UNITS-1:0]                      core_busy;
    logic [mul_pkg::NUM_UNITS-1:0]                      core_valid;
    logic [mul_pkg::NUM_UNITS-1:0]                      core_free;
    logic [mul_pkg::NUM_UNITS-1:0]                      core_ready;
    logic [mul_pkg::NUM_UNITS-1:0][mul_pkg::DATA_W-1:0] core_result;
    logic [mul_pkg::NUM_UNITS-1:0]                      wb_sel;

    // destination and commit id per core, captured at start
    logic [mul_pkg::NUM_UNITS-1:0][mul_pkg::ADDR_W-1:0] saved_waddr;
    logic [mul_pkg::NUM_UNITS-1:0][mul_pkg::CID_W-1:0]  saved_cid;

    // source holds its request while the buffer is occupied
    assign stall_o = buf_valid_q && req_i;

    // new issue is blocked by the interrupt line
    assign take = req_i && !stall_o && !int_i;

    // buffered request goes first, even under interrupt
    assign cand_valid = buf_valid_q || take;
    assign cand       = buf_valid_q ? buf_q : req_data_i;

    // first enabled free core gets the request
    always_comb begin
        core_start = '0;
        for (int i = 0; i < mul_pkg::NUM_UNITS; i++) begin
            if (cand_valid && unit_en_i[i] && core_free[i] && (core_start == '0)) begin
                core_start[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid_q <= 1'b0;
        end else if (take && (core_start == '0)) begin
            buf_valid_q <= 1'b1;
        end else if (buf_valid_q && (core_start != '0)) begin
            buf_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take && (core_start == '0)) begin
            buf_q <= req_data_i;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < mul_pkg::NUM_UNITS; i++) begin
            if (core_start[i]) begin
                saved_waddr[i] <= cand.waddr;
                saved_cid[i]   <= cand.commit_id;
            end
        end
    end

    for (genvar g = 0; g < mul_pkg::NUM_UNITS; g++) begin : g_core
        // a core holding an unread result cannot restart
        assign core_free[g]  = !core_busy[g] && !core_valid[g];
        assign core_ready[g] = wb_ready_i && wb_sel[g];

        mul_core u_core (
            .clk      (clk),
            .rst_n    (rst_n),
            .start_i  (core_start[g]),
            .op_i     (cand.op),
            .a_i      (cand.rs1),
            .b_i      (cand.rs2),
            .ready_i  (core_ready[g]),
            .result_o (core_result[g]),
            .busy_o   (core_busy[g]),
            .valid_o  (core_valid[g])
        );
    end

    // write-back select, lowest index wins
    always_comb begin
        wb_sel    = '0;
        wb_data_o = '0;
        for (int i = 0; i < mul_pkg::NUM_UNITS; i++) begin
            if (core_valid[i] && (wb_sel == '0)) begin
                wb_sel[i]           = 1'b1;
                wb_data_o.wdata     = core_result[i];
                wb_data_o.waddr     = saved_waddr[i];
                wb_data_o.commit_id = saved_cid[i];
            end
        end
    end

    assign wb_valid_o = |core_valid;

    // one pulse per completed write-back handshake
    assign retire_o = wb_valid_o && wb_ready_i;

endmodule

//--- mul_top.sv
module mul_top (
    input  logic                       clk,
    input  logic                       rst_n,

    // issue
    input  logic                       req_i,
    input  mul_pkg::mul_req_t          req_data_i,
    output logic                       stall_o,
    input  logic                       int_i,

    // write-back
    input  logic                       wb_ready_i,
    output logic                       wb_valid_o,
    output mul_pkg::mul_wb_t           wb_data_o,

    // configuration
    input  logic                       cfg_we_i,
    input  logic                       cfg_addr_i,
    input  logic [mul_pkg::DATA_W-1:0] cfg_wdata_i,
    output logic [mul_pkg::DATA_W-1:0] cfg_rdata_o
);

    logic [mul_pkg::NUM_UNITS-1:0] unit_en;
    logic                          retire;

    mul_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .retire_i    (retire),
        .cfg_rdata_o (cfg_rdata_o),
        .unit_en_o   (unit_en)
    );

    mul_unit u_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .req_data_i  (req_data_i),
        .int_i       (int_i),
        .unit_en_i   (unit_en),
        .wb_ready_i  (wb_ready_i),
        .stall_o     (stall_o),
        .wb_valid_o  (wb_valid_o),
        .wb_data_o   (wb_data_o),
        .retire_o    (retire)
    );

endmodule

//--- tb_mul_top.sv
module tb_mul_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS      = 6;
    localparam int MAX_REQS       = 80;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * MAX_REQS * 40 + 1000;

    logic                       clk;
    logic                       rst_n;
    logic                       req_i;
    mul_pkg::mul_req_t          req_data_i;
    logic                       stall_o;
    logic                       int_i;
    logic                       wb_ready_i;
    logic                       wb_valid_o;
    mul_pkg::mul_wb_t           wb_data_o;
    logic                       cfg_we_i;
    logic                       cfg_addr_i;
    logic [mul_pkg::DATA_W-1:0] cfg_wdata_i;
    logic [mul_pkg::DATA_W-1:0] cfg_rdata_o;

    integer                     seed = 32'h5da086c1;
    int                         cyc = 0;
    int                         err_cnt = 0;
    int                         err_at_start = 0;
    int                         tests_run = 0;
    int                         tests_failed = 0;
    string                      test_name = "reset";
    logic [mul_pkg::CID_W-1:0]  cid_next = '0;

    // expected write-backs looked up by commit id
    mul_pkg::mul_wb_t           exp_q[$];

    // monitor state updated on the falling edge
    logic                       hs_done = 1'b0;
    logic                       ref_hit = 1'b0;
    mul_pkg::mul_wb_t           ref_wb = '0;
    mul_pkg::mul_wb_t           mon_wb = '0;
    int                         hs_count = 0;
    int                         hs_gap = 0;
    int                         last_hs = 0;
    logic                       ser_mode = 1'b0;
    logic                       lat_check_en = 1'b0;
    logic                       lat_done = 1'b0;
    logic                       valid_prev = 1'b0;
    int                         acc_edge = 0;
    int                         lat_meas = 0;
    int                         lat_cnt = 0;
    logic                       hold_pend = 1'b0;
    logic                       hold_done = 1'b0;
    logic                       hold_valid = 1'b0;
    mul_pkg::mul_wb_t           held_wb = '0;
    mul_pkg::mul_wb_t           hold_exp = '0;
    mul_pkg::mul_wb_t           hold_cur = '0;
    int                         hold_cnt = 0;
    logic                       stall_seen = 1'b0;

    logic [mul_pkg::DATA_W-1:0] corner_vals [4] = '{32'h0, 32'hffff_ffff, 32'h8000_0000,
                                                    32'h7fff_ffff};
    mul_pkg::mul_op_e           op_list [4] = '{mul_pkg::OP_MUL, mul_pkg::OP_MULH,
                                                mul_pkg::OP_MULHSU, mul_pkg::OP_MULHU};

    mul_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .req_data_i  (req_data_i),
        .stall_o     (stall_o),
        .int_i       (int_i),
        .wb_ready_i  (wb_ready_i),
        .wb_valid_o  (wb_valid_o),
        .wb_data_o   (wb_data_o),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // sign or zero extend each operand per rv32m form and take the low or high word
    function automatic logic [mul_pkg::DATA_W-1:0] ref_result(mul_pkg::mul_op_e op,
            logic [mul_pkg::DATA_W-1:0] a, logic [mul_pkg::DATA_W-1:0] b);
        logic signed [2*mul_pkg::DATA_W-1:0] ax;
        logic signed [2*mul_pkg::DATA_W-1:0] bx;
        logic signed [2*mul_pkg::DATA_W-1:0] p;
        ax = {{mul_pkg::DATA_W{a[mul_pkg::DATA_W-1]}}, a};
        if (op == mul_pkg::OP_MULHU) ax = {{mul_pkg::DATA_W{1'b0}}, a};
        bx = {{mul_pkg::DATA_W{1'b0}}, b};
        if (op == mul_pkg::OP_MUL || op == mul_pkg::OP_MULH) begin
            bx = {{mul_pkg::DATA_W{b[mul_pkg::DATA_W-1]}}, b};
        end
        p = ax * bx;
        if (op == mul_pkg::OP_MUL) return p[mul_pkg::DATA_W-1:0];
        return p[2*mul_pkg::DATA_W-1:mul_pkg::DATA_W];
    endfunction

    function automatic int find_cid(logic [mul_pkg::CID_W-1:0] cid);
        foreach (exp_q[i]) begin
            if (exp_q[i].commit_id == cid) return i;
        end
        return -1;
    endfunction

    // handshakes and held results observed on the falling edge
    always @(negedge clk) begin
        int idx;
        hs_done   = 1'b0;
        lat_done  = 1'b0;
        hold_done = 1'b0;
        if (rst_n) begin
            if (req_i && !stall_o && !int_i) acc_edge = cyc + 1;
            if (wb_valid_o && !valid_prev && lat_check_en) begin
                lat_meas = cyc - acc_edge;
                lat_done = 1'b1;
                lat_cnt++;
            end
            valid_prev = wb_valid_o;
            if (hold_pend) begin
                hold_done  = 1'b1;
                hold_exp   = held_wb;
                hold_cur   = wb_data_o;
                hold_valid = wb_valid_o;
                hold_cnt++;
            end
            hold_pend = wb_valid_o && !wb_ready_i;
            held_wb   = wb_data_o;
            if (stall_o) stall_seen = 1'b1;
            if (wb_valid_o && wb_ready_i) begin
                mon_wb  = wb_data_o;
                idx     = find_cid(wb_data_o.commit_id);
                ref_hit = (idx >= 0);
                if (ref_hit) begin
                    ref_wb = exp_q[idx];
                    exp_q.delete(idx);
                end
                hs_gap  = cyc - last_hs;
                last_hs = cyc;
                hs_count++;
                hs_done = 1'b1;
            end
        end
    end

    a_wb_known: assert property (@(posedge clk) disable iff (!rst_n) hs_done |-> ref_hit)
    else begin
        $display("%s: write-back with commit id %0d has no pending request",
                 test_name, mon_wb.commit_id);
        err_cnt++;
    end

    a_wb_value: assert property (@(posedge clk) disable iff (!rst_n)
            hs_done && ref_hit |-> mon_wb == ref_wb)
    else begin
        $display("FAIL %s: write-back expected %h actual %h", test_name, ref_wb, mon_wb);
        err_cnt++;
    end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
            lat_done |-> lat_meas == mul_pkg::MUL_CYCLES)
    else begin
        $display("FAIL %s: latency expected %0d actual %0d", test_name,
                 mul_pkg::MUL_CYCLES, lat_meas);
        err_cnt++;
    end

    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n) hold_done |-> hold_valid)
    else begin
        $display("%s: wb_valid_o dropped before the result was taken", test_name);
        err_cnt++;
    end

    a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
            hold_done |-> hold_cur == hold_exp)
    else begin
        $display("FAIL %s: held write-back expected %h actual %h", test_name, hold_exp, hold_cur);
        err_cnt++;
    end

    // with one enabled unit results are at least one full multiply apart
    a_serial: assert property (@(posedge clk) disable iff (!rst_n)
            hs_done && ser_mode |-> hs_gap >= mul_pkg::MUL_CYCLES)
    else begin
        $display("FAIL %s: write-back spacing expected >= %0d actual %0d", test_name,
                 mul_pkg::MUL_CYCLES, hs_gap);
        err_cnt++;
    end

    task automatic check_eq(string what, logic [31:0] exp, logic [31:0] act);
        assert (act == exp)
        else begin
            $display("FAIL %s: %s expected %0h actual %0h", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond)
        else begin
            $display("%s: %s", test_name, what);
            err_cnt++;
        end
    endtask

    // all tasks start and end 1 ns after a rising edge
    task automatic send_req(mul_pkg::mul_op_e op, logic [31:0] a, logic [31:0] b);
        mul_pkg::mul_req_t r;
        mul_pkg::mul_wb_t  e;
        logic [31:0]       rnd;
        rnd         = $random(seed);
        r.op        = op;
        r.rs1       = a;
        r.rs2       = b;
        r.waddr     = rnd[mul_pkg::ADDR_W-1:0];
        r.commit_id = cid_next;
        cid_next    = cid_next + 1'b1;
        e.wdata     = ref_result(op, a, b);
        e.waddr     = r.waddr;
        e.commit_id = r.commit_id;
        req_i       = 1'b1;
        req_data_i  = r;
        @(negedge clk);
        while (stall_o) @(negedge clk);
        exp_q.push_back(e);
        @(posedge clk);
        #1;
        req_i = 1'b0;
    endtask

    task automatic cfg_write(logic addr, logic [31:0] data);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(posedge clk);
        #1;
        cfg_we_i = 1'b0;
    endtask

    task automatic cfg_read(logic addr, output logic [31:0] data);
        cfg_addr_i = addr;
        @(negedge clk);
        data = cfg_rdata_o;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic start_test(string name);
        test_name    = name;
        err_at_start = err_cnt;
        stall_seen   = 1'b0;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt != err_at_start) begin
            tests_failed++;
            $display("%s: failed", test_name);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    initial begin
        while (cyc < TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0] a_val;
        logic [31:0] b_val;
        logic [31:0] rd;
        int          hs_before;
        rst_n       = 1'b0;
        req_i       = 1'b0;
        req_data_i  = '0;
        int_i       = 1'b0;
        wb_ready_i  = 1'b1;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = mul_pkg::CFG_ADDR_MASK;
        cfg_wdata_i = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        start_test("mul_ops");
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    send_req(op_list[k], corner_vals[i], corner_vals[j]);
                end
            end
            for (int i = 0; i < 4; i++) begin
                a_val = $random(seed);
                b_val = $random(seed);
                send_req(op_list[k], a_val, b_val);
            end
        end
        wait_drain();
        end_test();

        start_test("latency");
        lat_cnt      = 0;
        lat_check_en = 1'b1;
        for (int k = 0; k < 4; k++) begin
            a_val = $random(seed);
            b_val = $random(seed);
            send_req(op_list[k], a_val, b_val);
            wait_drain();
        end
        lat_check_en = 1'b0;
        check_eq("latency checks", 32'd4, lat_cnt);
        end_test();

        // two cores plus the skid buffer fill up and the fourth request stalls
        start_test("back_to_back");
        hold_cnt   = 0;
        wb_ready_i = 1'b0;
        fork
            begin
                for (int k = 0; k < 4; k++) begin
                    a_val = $random(seed);
                    b_val = $random(seed);
                    send_req(op_list[k], a_val, b_val);
                end
            end
            begin
                repeat (50) @(posedge clk);
                #1;
                wb_ready_i = 1'b1;
            end
        join
        wait_drain();
        check_true(stall_seen, "stall_o never rose with both cores and the buffer full");
        check_true(hold_cnt > 0, "no write-back was held while wb_ready_i was low");
        end_test();

        start_test("interrupt");
        hs_before  = hs_count;
        int_i      = 1'b1;
        req_i      = 1'b1;
        req_data_i = '{op: mul_pkg::OP_MUL, rs1: 32'd3, rs2: 32'd5, waddr: 5'd1,
                       commit_id: cid_next};
        @(posedge clk);
        #1;
        req_i = 1'b0;
        int_i = 1'b0;
        repeat (2 * mul_pkg::MUL_CYCLES) @(posedge clk);
        #1;
        cfg_read(mul_pkg::CFG_ADDR_COUNT, rd);
        check_eq("retire count", hs_before, rd);
        end_test();

        start_test("unit_mask");
        cfg_write(mul_pkg::CFG_ADDR_MASK, 32'd2);
        cfg_read(mul_pkg::CFG_ADDR_MASK, rd);
        check_eq("mask", 32'd2, rd);
        ser_mode = 1'b1;
        for (int k = 0; k < 3; k++) begin
            a_val = $random(seed);
            b_val = $random(seed);
            send_req(op_list[k], a_val, b_val);
        end
        wait_drain();
        ser_mode = 1'b0;
        check_true(stall_seen, "stall_o never rose with a single unit enabled");
        cfg_write(mul_pkg::CFG_ADDR_MASK, 32'd3);
        cfg_read(mul_pkg::CFG_ADDR_MASK, rd);
        check_eq("mask", 32'd3, rd);
        end_test();

        start_test("retire_count");
        cfg_read(mul_pkg::CFG_ADDR_COUNT, rd);
        check_eq("retire count", hs_count, rd);
        cfg_write(mul_pkg::CFG_ADDR_COUNT, 32'd0);
        cfg_read(mul_pkg::CFG_ADDR_COUNT, rd);
        check_eq("cleared count", 32'd0, rd);
        for (int k = 0; k < 2; k++) begin
            a_val = $random(seed);
            b_val = $random(seed);
            send_req(op_list[a_val[1:0]], a_val, b_val);
        end
        wait_drain();
        cfg_read(mul_pkg::CFG_ADDR_COUNT, rd);
        check_eq("count after clear", 32'd2, rd);
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- src.f
mul_pkg.sv
mul_core.sv
mul_regs.sv
mul_unit.sv
mul_top.sv
tb_mul_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_mul_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module $(TOP)
LOG       := sim.log

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^All tests passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
